// ==== flist.f ====
rtl/port_pkg.sv
rtl/led_pkg.sv
rtl/port_status_sync.sv
rtl/led_frame_builder.sv
rtl/led_sreg_shifter.sv
rtl/fpga_led_status.sv
bench/tb_fpga_led_status.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fpga_led_status
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= *** PASSED ***

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv bench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_fpga_led_status.sv ====
// Board LED status testbench

`timescale 1ns/1ns

module tb_fpga_led_status;

    import port_pkg::*;
    import led_pkg::*;

    localparam int unsigned PRESCALE    = 3;
    localparam bit          INVERT      = 1'b1;
    localparam int unsigned PPS_STRETCH = 50;

    localparam int RESET_CYCLES       = 8;
    localparam int PATTERNS           = 40;
    localparam int FRAMES_PER_PATTERN = 3;
    localparam int PPS_GAP            = PPS_STRETCH / 2;

    // Two halves per bit plus the load half
    localparam int FRAME_CYCLES   = (2 * FRAME_W + 1) * (PRESCALE + 1);
    localparam int TOTAL_FRAMES   = PATTERNS * FRAMES_PER_PATTERN + 2;
    localparam int PPS_CYCLES     = 2 * (3 * PPS_STRETCH + 30);
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES * TOTAL_FRAMES + PPS_CYCLES
                                    + RESET_CYCLES + 500;

    logic                  clk_125mhz;
    logic                  reset;
    logic [PORT_COUNT-1:0] qsfp_rx_status;
    logic [CAGE_COUNT-1:0] qsfp_mod_prsnt_n;
    logic                  ptp_pps;

    logic       led_sreg_d;
    logic       led_sreg_ld;
    logic       led_sreg_clk;
    logic [1:0] led_bmc;
    logic [1:0] led_exp;

    logic [31:0] lfsr_state = 32'h5b29;

    // Frame capture state
    logic       sclk_prev;
    logic       ld_prev;
    logic       seen_ld;
    led_frame_t shift_word;
    led_frame_t captured_word;
    int         edge_count;
    int         frame_count = 0;
    int         gap_checks = 0;

    fpga_led_status #(
        .PRESCALE    (PRESCALE),
        .INVERT      (INVERT),
        .PPS_STRETCH (PPS_STRETCH)
    ) fpga_led_status_i (
        .clk_125mhz       (clk_125mhz),
        .reset            (reset),
        .qsfp_rx_status   (qsfp_rx_status),
        .qsfp_mod_prsnt_n (qsfp_mod_prsnt_n),
        .ptp_pps          (ptp_pps),
        .led_sreg_d       (led_sreg_d),
        .led_sreg_ld      (led_sreg_ld),
        .led_sreg_clk     (led_sreg_clk),
        .led_bmc          (led_bmc),
        .led_exp          (led_exp)
    );

    initial clk_125mhz = 1'b0;
    always #4 clk_125mhz = ~clk_125mhz;

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        if (expected !== actual) begin
            $display("mismatch at %0t ns: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // LED 7 first with green ahead of red
    function automatic led_frame_t expected_frame(input logic [PORT_COUNT-1:0] rx,
                                                  input logic [CAGE_COUNT-1:0] prsnt_n);
        led_frame_t word;
        logic       green;
        logic       red;
        word = '0;
        for (int n = LED_COUNT - 1; n >= 0; n--) begin
            green = rx[n];
            red   = ~prsnt_n[n / LANES_PER_CAGE] & ~rx[n];
            word  = {word[FRAME_W-3:0], green, red};
        end
        if (INVERT) begin
            word = ~word;
        end
        return word;
    endfunction

    task automatic wait_frame(output led_frame_t word);
        int target;
        target = frame_count + 1;
        wait (frame_count >= target);
        word = captured_word;
    endtask

    // One PPS pulse and an optional second one at edge second_at
    task automatic measure_pps(input int second_at, output int rise_delay,
                               output int high_cycles);
        int   ended;
        logic seen_high;
        logic bmc;
        rise_delay  = -1;
        high_cycles = 0;
        ended       = 0;
        seen_high   = 1'b0;
        @(posedge clk_125mhz);
        ptp_pps <= 1'b1;
        for (int k = 1; k <= 3 * PPS_STRETCH + 20 && ended == 0; k++) begin
            @(posedge clk_125mhz);
            if (k == second_at) begin
                ptp_pps <= 1'b1;
            end else if (k == 1 || k == second_at + 1) begin
                ptp_pps <= 1'b0;
            end
            bmc = led_bmc[0];
            check_value(1, 32'(led_exp[1] != bmc), "led_exp[1] is inverse of led_bmc[0]");
            check_value(1, 32'(led_exp[0]), "led_exp[0] held high");
            check_value(0, 32'(led_bmc[1]), "led_bmc[1] held low");
            if (bmc) begin
                if (!seen_high) begin
                    seen_high  = 1'b1;
                    rise_delay = k - 1;
                end
                high_cycles++;
            end else if (seen_high) begin
                ended = 1;
            end
        end
        check_value(1, 32'(ended), "stretched PPS returned low");
    endtask

    // Serial frame capture on the system clock
    always @(posedge clk_125mhz) begin
        if (reset) begin
            sclk_prev  = 1'b0;
            ld_prev    = 1'b0;
            seen_ld    = 1'b0;
            edge_count = 0;
        end else begin
            if (led_sreg_clk && !sclk_prev) begin
                shift_word = {shift_word[FRAME_W-2:0], led_sreg_d};
                edge_count++;
            end
            if (led_sreg_ld && !ld_prev) begin
                if (seen_ld) begin
                    check_value(FRAME_W, 32'(edge_count), "shift clocks per frame");
                    gap_checks++;
                end
                seen_ld       = 1'b1;
                edge_count    = 0;
                captured_word = shift_word;
                frame_count++;
            end
            sclk_prev = led_sreg_clk;
            ld_prev   = led_sreg_ld;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_125mhz);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        logic [31:0]           rnd;
        logic [PORT_COUNT-1:0] rx;
        logic [CAGE_COUNT-1:0] prsnt_n;
        led_frame_t            word;
        int                    rise_delay;
        int                    high_cycles;

        reset            = 1'b1;
        qsfp_rx_status   = '0;
        qsfp_mod_prsnt_n = '1;
        ptp_pps          = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_125mhz);
        reset <= 1'b0;
        check_value(0, 32'(led_sreg_clk), "led_sreg_clk low after reset");
        check_value(0, 32'(led_sreg_ld), "led_sreg_ld low after reset");
        check_value(0, 32'(led_bmc[0]), "led_bmc[0] low after reset");
        check_value(0, 32'(fpga_led_status_i.pps_str), "pps_str low after reset");
        check_value(1, 32'(led_exp[0]), "led_exp[0] high after reset");

        // Align to a frame boundary
        wait_frame(word);

        for (int p = 0; p < PATTERNS; p++) begin
            random_bits(PORT_COUNT, rnd);
            rx = rnd[PORT_COUNT-1:0];
            random_bits(CAGE_COUNT, rnd);
            prsnt_n = rnd[CAGE_COUNT-1:0];
            @(posedge clk_125mhz);
            qsfp_rx_status   <= rx;
            qsfp_mod_prsnt_n <= prsnt_n;
            // First frame may still carry the old pattern
            wait_frame(word);
            wait_frame(word);
            check_value(32'(expected_frame(rx, prsnt_n)), 32'(word), "captured LED frame");
            wait_frame(word);
        end
        check_value(1, 32'(gap_checks >= PATTERNS * FRAMES_PER_PATTERN),
                    "frame spacing checked");

        repeat (10) @(posedge clk_125mhz);
        measure_pps(0, rise_delay, high_cycles);
        check_value(3, 32'(rise_delay), "PPS stretch rise delay");
        check_value(PPS_STRETCH, 32'(high_cycles), "PPS stretch length");

        repeat (10) @(posedge clk_125mhz);
        measure_pps(PPS_GAP, rise_delay, high_cycles);
        check_value(3, 32'(rise_delay), "retriggered PPS rise delay");
        check_value(PPS_GAP + PPS_STRETCH, 32'(high_cycles), "retriggered PPS length");

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== rtl/fpga_led_status.sv ====
// Board LED status top level

`timescale 1ns/1ns

module fpga_led_status #(
    parameter int unsigned PRESCALE    = 63,
    parameter bit          INVERT      = 1'b1,
    parameter int unsigned PPS_STRETCH = 125000
) (
    input  logic                            clk_125mhz,
    input  logic                            reset,

    input  logic [port_pkg::PORT_COUNT-1:0] qsfp_rx_status,
    input  logic [port_pkg::CAGE_COUNT-1:0] qsfp_mod_prsnt_n,
    input  logic                            ptp_pps,

    output logic                            led_sreg_d,
    output logic                            led_sreg_ld,
    output logic                            led_sreg_clk,
    output logic [1:0]                      led_bmc,
    output logic [1:0]                      led_exp
);

    import port_pkg::*;
    import led_pkg::*;

    port_status_t status;
    led_frame_t   frame;
    sreg_pins_t   sreg_pins;
    logic         pps_str;

    port_status_sync port_status_sync_i (
        .clk_125mhz       (clk_125mhz),
        .reset            (reset),
        .qsfp_rx_status   (qsfp_rx_status),
        .qsfp_mod_prsnt_n (qsfp_mod_prsnt_n),
        .ptp_pps          (ptp_pps),
        .status           (status)
    );

    led_frame_builder #(
        .INVERT      (INVERT),
        .PPS_STRETCH (PPS_STRETCH)
    ) led_frame_builder_i (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .status     (status),
        .frame      (frame),
        .pps_str    (pps_str)
    );

    led_sreg_shifter #(
        .PRESCALE (PRESCALE)
    ) led_sreg_shifter_i (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .frame      (frame),
        .pins       (sreg_pins)
    );

    assign led_sreg_d   = sreg_pins.d;
    assign led_sreg_ld  = sreg_pins.ld;
    assign led_sreg_clk = sreg_pins.clk;

    // BMC LED blinks with PPS while the expansion LED goes dark
    assign led_bmc = {1'b0, pps_str};
    assign led_exp = {~pps_str, 1'b1};

endmodule

// ==== rtl/led_sreg_shifter.sv ====
// LED shift register driver

`timescale 1ns/1ns

module led_sreg_shifter #(
    parameter int unsigned PRESCALE = 63
) (
    input  logic                clk_125mhz,
    input  logic                reset,

    input  led_pkg::led_frame_t frame,

    output led_pkg::sreg_pins_t pins
);

    import led_pkg::*;

    localparam int CNT_W = (PRESCALE > 0) ? $clog2(PRESCALE + 1) : 1;
    localparam int IDX_W = $clog2(FRAME_W);

    logic [CNT_W-1:0] cnt;
    logic             half;
    logic             ld_phase;
    logic [IDX_W-1:0] idx;
    led_frame_t       frame_reg;

    logic tick;
    logic start_frame;

    assign tick        = (cnt == '0);
    assign start_frame = tick & ld_phase;

    // Frame is latched once per pass
    always_ff @(posedge clk_125mhz) begin
        if (start_frame) begin
            frame_reg <= frame;
        end
    end

    // Reset leaves the FSM at the end of a load half, so a pass starts right away
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            cnt      <= '0;
            half     <= 1'b0;
            ld_phase <= 1'b1;
            idx      <= '0;
            pins     <= '0;
        end else if (!tick) begin
            cnt <= cnt - 1'b1;
        end else begin
            cnt <= CNT_W'(PRESCALE);
            if (ld_phase) begin
                // First bit of a new frame
                ld_phase <= 1'b0;
                half     <= 1'b0;
                idx      <= IDX_W'(FRAME_W - 1);
                pins.d   <= frame[FRAME_W-1];
                pins.ld  <= 1'b0;
                pins.clk <= 1'b0;
            end else if (!half) begin
                half     <= 1'b1;
                pins.clk <= 1'b1;
            end else begin
                half     <= 1'b0;
                pins.clk <= 1'b0;
                if (idx == '0) begin
                    // Latch the register outputs
                    ld_phase <= 1'b1;
                    pins.ld  <= 1'b1;
                end else begin
                    idx    <= idx - 1'b1;
                    pins.d <= frame_reg[idx - 1'b1];
                end
            end
        end
    end

endmodule

// ==== rtl/led_frame_builder.sv ====
// LED frame builder and PPS stretcher

`timescale 1ns/1ns

module led_frame_builder #(
    parameter bit          INVERT      = 1'b1,
    parameter int unsigned PPS_STRETCH = 125000
) (
    input  logic                   clk_125mhz,
    input  logic                   reset,

    input  port_pkg::port_status_t status,

    output led_pkg::led_frame_t    frame,
    output logic                   pps_str
);

    import port_pkg::*;
    import led_pkg::*;

    localparam int CNT_W = $clog2(PPS_STRETCH + 1);

    led_frame_t frame_next;

    logic             pps_prev;
    logic             pps_rise;
    logic [CNT_W-1:0] pps_cnt;

    // Green when the link is up, red when the cage is fitted but the link is down
    always_comb begin
        for (int n = 0; n < LED_COUNT; n++) begin
            frame_next[2*n+1] = status.rx_up[n];
            frame_next[2*n]   = status.cage_present[n / LANES_PER_CAGE] & ~status.rx_up[n];
        end
        if (INVERT) begin
            frame_next = ~frame_next;
        end
    end

    // All LEDs dark out of reset
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            frame <= {FRAME_W{INVERT}};
        end else begin
            frame <= frame_next;
        end
    end

    assign pps_rise = status.pps & ~pps_prev;

    // Stretch the PPS pulse so it shows on an LED
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            pps_prev <= 1'b0;
            pps_str  <= 1'b0;
            pps_cnt  <= '0;
        end else begin
            pps_prev <= status.pps;
            if (pps_rise) begin
                pps_str <= 1'b1;
                pps_cnt <= CNT_W'(PPS_STRETCH - 1);
            end else if (pps_str) begin
                if (pps_cnt == '0) begin
                    pps_str <= 1'b0;
                end else begin
                    pps_cnt <= pps_cnt - 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/port_status_sync.sv ====
// Board status input synchronizer

`timescale 1ns/1ns

module port_status_sync (
    input  logic                              clk_125mhz,
    input  logic                              reset,

    input  logic [port_pkg::PORT_COUNT-1:0]   qsfp_rx_status,
    input  logic [port_pkg::CAGE_COUNT-1:0]   qsfp_mod_prsnt_n,
    input  logic                              ptp_pps,

    output port_pkg::port_status_t            status
);

    import port_pkg::*;

    port_status_t sync_1;
    port_status_t sync_2;

    // Presence pins are active low on the cages
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1.rx_up        <= qsfp_rx_status;
            sync_1.cage_present <= ~qsfp_mod_prsnt_n;
            sync_1.pps          <= ptp_pps;
            sync_2              <= sync_1;
        end
    end

    assign status = sync_2;

endmodule

// ==== rtl/led_pkg.sv ====
// LED shift register definitions

package led_pkg;

    // One bicolor LED per Ethernet port
    localparam int LED_COUNT = port_pkg::PORT_COUNT;

    // Green and red bit per LED
    localparam int FRAME_W = 2 * LED_COUNT;

    // Shift order with the MSB going out first
    typedef logic [FRAME_W-1:0] led_frame_t;

    // Pins of the external LED shift register
    typedef struct packed {
        logic d;
        logic ld;
        logic clk;
    } sreg_pins_t;

endpackage

// ==== rtl/port_pkg.sv ====
// Port status definitions

package port_pkg;

    // Ethernet ports on the two QSFP28 cages
    localparam int PORT_COUNT = 8;

    // Ports carried by one cage
    localparam int LANES_PER_CAGE = 4;

    localparam int CAGE_COUNT = PORT_COUNT / LANES_PER_CAGE;

    // Synchronized board status with presence already active high
    typedef struct packed {
        logic [PORT_COUNT-1:0] rx_up;
        logic [CAGE_COUNT-1:0] cage_present;
        logic                  pps;
    } port_status_t;

endpackage
